/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0a;
  localparam opcode_t OP_ANDI  = 6'h0c;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_XORI  = 6'h0e;
  localparam opcode_t OP_LUI   = 6'h0f;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // funct codes for r-type
  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_SRL  = 6'h02;
  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_XOR  = 6'h26;
  localparam funct_t FN_SLT  = 6'h2a;
  localparam funct_t FN_SLTU = 6'h2b;

  // fixed register numbers
  localparam reg_idx_t REG_V0 = 5'd2;
  localparam reg_idx_t REG_RA = 5'd31;

  localparam word_t RESET_VECTOR = 32'hbfc0_0000;

endpackage

/* logic/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_HALTED,
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK
  } cpu_state_t;

  // op class chosen by the controller; EQ/NE are used by beq/bne
  typedef enum logic [3:0] {
    CLS_ADD,
    CLS_SUB,
    CLS_FUNCT,
    CLS_AND,
    CLS_OR,
    CLS_XOR,
    CLS_SLT,
    CLS_LUI,
    CLS_EQ,
    CLS_NE
  } alu_class_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI,
    ALU_EQ,
    ALU_NE
  } alu_func_t;

  typedef enum logic [2:0] {
    SRCB_REG_B,
    SRCB_FOUR,
    SRCB_SIGN_IMM,
    SRCB_SIGN_IMM_X4,
    SRCB_ZERO_IMM
  } srcb_sel_t;

  typedef enum logic [1:0] {
    PC_ALU_RESULT,
    PC_BRANCH_TARGET,
    PC_JUMP_FIELD,
    PC_REG_A
  } pc_src_t;

  typedef enum logic [1:0] {
    DST_RT,
    DST_RD,
    DST_RA31
  } reg_dst_t;

endpackage

/* logic/mips_cpu_instruction_reg.sv */
module mips_cpu_instruction_reg
  import mips_isa_pkg::*;
(
  input  logic        clk,
  input  logic        ir_write,
  input  word_t       memreaddata,
  output opcode_t     opcode,
  output reg_idx_t    rs,
  output reg_idx_t    rt,
  output reg_idx_t    rd,
  output logic [4:0]  shamt,
  output funct_t      funct,
  output imm_t        immediate,
  output logic [25:0] jump_field
);

  word_t instr;

  // captured in the cycle the fetch completes
  always_ff @(posedge clk) begin
    if (ir_write) begin
      instr <= memreaddata;
    end
  end

  assign opcode     = instr[31:26];
  assign rs         = instr[25:21];
  assign rt         = instr[20:16];
  assign rd         = instr[15:11];
  assign shamt      = instr[10:6];
  assign funct      = instr[5:0];
  assign immediate  = instr[15:0];
  assign jump_field = instr[25:0];

endmodule

/* logic/mips_cpu_register_file.sv */
module mips_cpu_register_file
  import mips_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     write_enable,
  input  reg_idx_t read_reg_1,
  input  reg_idx_t read_reg_2,
  input  reg_idx_t write_reg,
  input  word_t    write_data,
  output word_t    read_data_1,
  output word_t    read_data_2,
  output word_t    read_data_v0
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_reg != '0) begin
      // $zero never changes
      regs[write_reg] <= write_data;
    end
  end

  assign read_data_1 = regs[read_reg_1];
  assign read_data_2 = regs[read_reg_2];

  // v0 tap for the result port
  assign read_data_v0 = regs[REG_V0];

endmodule

/* logic/mips_cpu_alu.sv */
module mips_cpu_alu
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  alu_func_t  alu_func,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       condition
);

  always_comb begin
    result    = '0;
    condition = 1'b0;
    case (alu_func)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLT: begin
        result = {31'b0, $signed(a) < $signed(b)};
      end
      ALU_SLTU: begin
        result = {31'b0, a < b};
      end
      // shifts act on the rt operand
      ALU_SLL: begin
        result = b << shamt;
      end
      ALU_SRL: begin
        result = b >> shamt;
      end
      ALU_LUI: begin
        result = {b[15:0], 16'h0000};
      end
      ALU_EQ: begin
        result    = a - b;
        condition = (a == b);
      end
      ALU_NE: begin
        result    = a - b;
        condition = (a != b);
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* logic/mips_cpu_alu_control.sv */
module mips_cpu_alu_control
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  alu_class_t alu_class,
  input  funct_t     funct,
  output alu_func_t  alu_func
);

  always_comb begin
    case (alu_class)
      CLS_ADD: alu_func = ALU_ADD;
      CLS_SUB: alu_func = ALU_SUB;
      CLS_AND: alu_func = ALU_AND;
      CLS_OR:  alu_func = ALU_OR;
      CLS_XOR: alu_func = ALU_XOR;
      CLS_SLT: alu_func = ALU_SLT;
      CLS_LUI: alu_func = ALU_LUI;
      CLS_EQ:  alu_func = ALU_EQ;
      CLS_NE:  alu_func = ALU_NE;
      // r-type, pick from funct
      default: begin
        case (funct)
          FN_ADDU: alu_func = ALU_ADD;
          FN_SUBU: alu_func = ALU_SUB;
          FN_AND:  alu_func = ALU_AND;
          FN_OR:   alu_func = ALU_OR;
          FN_XOR:  alu_func = ALU_XOR;
          FN_SLT:  alu_func = ALU_SLT;
          FN_SLTU: alu_func = ALU_SLTU;
          FN_SLL:  alu_func = ALU_SLL;
          FN_SRL:  alu_func = ALU_SRL;
          default: alu_func = ALU_ADD;
        endcase
      end
    endcase
  end

endmodule

/* logic/mips_cpu_controller.sv */
module mips_cpu_controller
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       waitrequest,
  input  logic       condition,
  input  opcode_t    opcode,
  input  funct_t     funct,
  input  logic       next_pc_zero,
  output cpu_state_t state,
  output logic       memread,
  output logic       memwrite,
  output logic       iord,
  output logic       ir_write,
  output logic       pc_write,
  output logic       branch_arm,
  output logic       reg_write,
  output logic       mem_to_reg,
  output logic       srca_reg,
  output logic       aluout_en,
  output srcb_sel_t  srcb_sel,
  output pc_src_t    pc_src,
  output reg_dst_t   reg_dst,
  output alu_class_t alu_class
);

  cpu_state_t next_state;
  cpu_state_t done_state;
  // low for the first cycle after reset so no request goes out during reset
  logic       run;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      run   <= 1'b0;
    end else begin
      state <= next_state;
      run   <= 1'b1;
    end
  end

  // instruction boundary, stop if the next fetch would be at 0
  assign done_state = next_pc_zero ? ST_HALTED : ST_FETCH;

  always_comb begin
    next_state = state;
    memread    = 1'b0;
    memwrite   = 1'b0;
    iord       = 1'b0;
    ir_write   = 1'b0;
    pc_write   = 1'b0;
    branch_arm = 1'b0;
    reg_write  = 1'b0;
    mem_to_reg = 1'b0;
    srca_reg   = 1'b0;
    aluout_en  = 1'b0;
    srcb_sel   = SRCB_REG_B;
    pc_src     = PC_ALU_RESULT;
    reg_dst    = DST_RT;
    alu_class  = CLS_ADD;
    case (state)
      ST_FETCH: begin
        // pc + 4 through the alu
        srcb_sel = SRCB_FOUR;
        if (run) begin
          memread  = 1'b1;
          ir_write = !waitrequest;
          pc_write = !waitrequest;
          if (!waitrequest) begin
            next_state = ST_DECODE;
          end
        end
      end
      ST_DECODE: begin
        aluout_en  = 1'b1;
        next_state = ST_EXECUTE;
        if (opcode == OP_J || opcode == OP_JAL) begin
          branch_arm = 1'b1;
          pc_src     = PC_JUMP_FIELD;
          // link address for jal
          srcb_sel   = SRCB_FOUR;
        end else begin
          srcb_sel = SRCB_SIGN_IMM_X4;
        end
      end
      ST_EXECUTE: begin
        srca_reg   = 1'b1;
        next_state = done_state;
        case (opcode)
          OP_RTYPE: begin
            if (funct == FN_JR) begin
              branch_arm = 1'b1;
              pc_src     = PC_REG_A;
            end else begin
              alu_class  = CLS_FUNCT;
              aluout_en  = 1'b1;
              next_state = ST_WRITEBACK;
            end
          end
          OP_ADDIU, OP_SLTI: begin
            srcb_sel   = SRCB_SIGN_IMM;
            alu_class  = (opcode == OP_SLTI) ? CLS_SLT : CLS_ADD;
            aluout_en  = 1'b1;
            next_state = ST_WRITEBACK;
          end
          OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            srcb_sel   = SRCB_ZERO_IMM;
            aluout_en  = 1'b1;
            next_state = ST_WRITEBACK;
            case (opcode)
              OP_ANDI: alu_class = CLS_AND;
              OP_ORI:  alu_class = CLS_OR;
              OP_XORI: alu_class = CLS_XOR;
              default: alu_class = CLS_LUI;
            endcase
          end
          OP_LW, OP_SW: begin
            // effective address
            srcb_sel   = SRCB_SIGN_IMM;
            aluout_en  = 1'b1;
            next_state = ST_MEMORY;
          end
          OP_BEQ, OP_BNE: begin
            alu_class  = (opcode == OP_BEQ) ? CLS_EQ : CLS_NE;
            pc_src     = PC_BRANCH_TARGET;
            branch_arm = condition;
          end
          OP_JAL: begin
            reg_write = 1'b1;
            reg_dst   = DST_RA31;
          end
          default: begin
            next_state = done_state;
          end
        endcase
      end
      ST_MEMORY: begin
        iord     = 1'b1;
        memread  = (opcode == OP_LW);
        memwrite = (opcode == OP_SW);
        if (!waitrequest) begin
          next_state = (opcode == OP_LW) ? ST_WRITEBACK : done_state;
        end
      end
      ST_WRITEBACK: begin
        reg_write  = 1'b1;
        mem_to_reg = (opcode == OP_LW);
        reg_dst    = (opcode == OP_RTYPE) ? DST_RD : DST_RT;
        next_state = done_state;
      end
      default: begin
        // halted until reset
        next_state = ST_HALTED;
      end
    endcase
  end

endmodule

/* logic/mips_cpu_bus.sv */
module mips_cpu_bus
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
#(
  parameter word_t RESET_PC = RESET_VECTOR
) (
  input  logic       clk,
  input  logic       reset,
  output logic       active,
  output word_t      register_v0,
  output word_t      mem_address,
  output logic       memwrite,
  output logic       memread,
  input  logic       waitrequest,
  output word_t      memwritedata,
  output logic [3:0] byteenable,
  input  word_t      memreaddata
);

  // datapath registers
  word_t pc;
  word_t a_reg;
  word_t b_reg;
  word_t mdr;
  word_t alu_out;
  word_t pending_target;
  logic  pending_valid;

  word_t alu_result, srca, srcb, pc_mux, pc_next;
  word_t sign_imm, zero_imm, jump_target;
  word_t read_data_1, read_data_2, write_data;
  reg_idx_t write_reg;
  logic condition;

  // instruction fields
  opcode_t     opcode;
  reg_idx_t    rs, rt, rd;
  logic [4:0]  shamt;
  funct_t      funct;
  imm_t        immediate;
  logic [25:0] jump_field;

  // control
  cpu_state_t state;
  logic iord, ir_write, pc_write, branch_arm, reg_write, mem_to_reg;
  logic srca_reg, aluout_en;
  srcb_sel_t  srcb_sel;
  pc_src_t    pc_src;
  reg_dst_t   reg_dst;
  alu_class_t alu_class;
  alu_func_t  alu_func;

  assign active       = (state != ST_HALTED);
  assign byteenable   = 4'b1111;
  assign memwritedata = b_reg;
  assign mem_address  = iord ? alu_out : pc;

  assign sign_imm    = {{16{immediate[15]}}, immediate};
  assign zero_imm    = {16'h0000, immediate};
  assign jump_target = {pc[31:28], jump_field, 2'b00};

  assign srca = srca_reg ? a_reg : pc;

  always_comb begin
    case (srcb_sel)
      SRCB_FOUR:        srcb = 32'd4;
      SRCB_SIGN_IMM:    srcb = sign_imm;
      SRCB_SIGN_IMM_X4: srcb = {sign_imm[29:0], 2'b00};
      SRCB_ZERO_IMM:    srcb = zero_imm;
      default:          srcb = b_reg;
    endcase
  end

  always_comb begin
    case (pc_src)
      PC_BRANCH_TARGET: pc_mux = alu_out;
      PC_JUMP_FIELD:    pc_mux = jump_target;
      PC_REG_A:         pc_mux = a_reg;
      default:          pc_mux = alu_result;
    endcase
  end

  // an armed target replaces pc + 4 at the delay slot's fetch
  assign pc_next = pending_valid ? pending_target : pc_mux;

  always_comb begin
    case (reg_dst)
      DST_RD:   write_reg = rd;
      DST_RA31: write_reg = REG_RA;
      default:  write_reg = rt;
    endcase
  end

  assign write_data = mem_to_reg ? mdr : alu_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc            <= RESET_PC;
      pending_valid <= 1'b0;
    end else begin
      if (pc_write) begin
        pc <= pc_next;
      end
      if (branch_arm) begin
        pending_valid <= 1'b1;
      end else if (pc_write) begin
        pending_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    // operands taken while the instruction decodes
    if (state == ST_DECODE) begin
      a_reg <= read_data_1;
      b_reg <= read_data_2;
    end
    if (memread && !waitrequest) begin
      mdr <= memreaddata;
    end
    if (aluout_en) begin
      alu_out <= alu_result;
    end
    if (branch_arm) begin
      pending_target <= pc_mux;
    end
  end

  mips_cpu_controller controller_i (
    .clk          (clk),
    .reset        (reset),
    .waitrequest  (waitrequest),
    .condition    (condition),
    .opcode       (opcode),
    .funct        (funct),
    .next_pc_zero (pc == '0),
    .state        (state),
    .memread      (memread),
    .memwrite     (memwrite),
    .iord         (iord),
    .ir_write     (ir_write),
    .pc_write     (pc_write),
    .branch_arm   (branch_arm),
    .reg_write    (reg_write),
    .mem_to_reg   (mem_to_reg),
    .srca_reg     (srca_reg),
    .aluout_en    (aluout_en),
    .srcb_sel     (srcb_sel),
    .pc_src       (pc_src),
    .reg_dst      (reg_dst),
    .alu_class    (alu_class)
  );

  mips_cpu_instruction_reg instruction_reg_i (
    .clk         (clk),
    .ir_write    (ir_write),
    .memreaddata (memreaddata),
    .opcode      (opcode),
    .rs          (rs),
    .rt          (rt),
    .rd          (rd),
    .shamt       (shamt),
    .funct       (funct),
    .immediate   (immediate),
    .jump_field  (jump_field)
  );

  mips_cpu_register_file register_file_i (
    .clk          (clk),
    .reset        (reset),
    .write_enable (reg_write),
    .read_reg_1   (rs),
    .read_reg_2   (rt),
    .write_reg    (write_reg),
    .write_data   (write_data),
    .read_data_1  (read_data_1),
    .read_data_2  (read_data_2),
    .read_data_v0 (register_v0)
  );

  mips_cpu_alu_control alu_control_i (
    .alu_class (alu_class),
    .funct     (funct),
    .alu_func  (alu_func)
  );

  mips_cpu_alu alu_i (
    .alu_func  (alu_func),
    .a         (srca),
    .b         (srcb),
    .shamt     (shamt),
    .result    (alu_result),
    .condition (condition)
  );

endmodule

/* test/avalon_ram_model.sv */
module avalon_ram_model
  import mips_isa_pkg::*;
#(
  parameter word_t PROG_BASE = RESET_VECTOR,
  parameter word_t DATA_BASE = 32'h0000_1000,
  parameter word_t SEED      = 32'd89
) (
  input  logic  clk,
  input  logic  memread,
  input  logic  memwrite,
  input  word_t address,
  input  word_t writedata,
  output logic  waitrequest,
  output word_t readdata
);

  // 256 program words and 64 data words
  word_t prog [256];
  word_t data [64];
  word_t lcg_state;
  logic  in_request;
  int    stall_left;

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // unmapped or unloaded words read back a pattern of the full address
  function automatic word_t fill_word(input word_t a);
    return {a[15:0], a[31:16]} ^ 32'h6b3c_91e5;
  endfunction

  function automatic word_t read_word(input word_t a);
    word_t poff;
    word_t doff;
    poff = a - PROG_BASE;
    doff = a - DATA_BASE;
    if (poff < 32'd1024) begin
      return prog[poff[9:2]];
    end else if (doff < 32'd256) begin
      return data[doff[7:2]];
    end
    return fill_word(a);
  endfunction

  task automatic clear_all();
    for (int i = 0; i < 256; i++) begin
      prog[i] = fill_word(PROG_BASE + 4 * i);
    end
    for (int i = 0; i < 64; i++) begin
      data[i] = fill_word(DATA_BASE + 4 * i);
    end
  endtask

  task automatic load_word(input word_t a, input word_t d);
    word_t poff;
    word_t doff;
    poff = a - PROG_BASE;
    doff = a - DATA_BASE;
    if (poff < 32'd1024) begin
      prog[poff[9:2]] = d;
    end else if (doff < 32'd256) begin
      data[doff[7:2]] = d;
    end
  endtask

  initial begin
    waitrequest = 1'b0;
    readdata    = '0;
    lcg_state   = SEED;
    in_request  = 1'b0;
    stall_left  = 0;
  end

  // responds a short delay after each rising edge
  always @(posedge clk) begin
    #5;
    readdata = read_word(address);
    if (memread || memwrite) begin
      if (!in_request) begin
        in_request = 1'b1;
        lcg_state  = lcg_next(lcg_state);
        // roughly one request in three is stalled
        stall_left = ((lcg_state >> 8) % 3 == 0) ? int'((lcg_state >> 12) % 4) : 0;
      end
      if (stall_left != 0) begin
        waitrequest = 1'b1;
        stall_left  = stall_left - 1;
      end else begin
        waitrequest = 1'b0;
        in_request  = 1'b0;
        if (memwrite) begin
          load_word(address, writedata);
        end
      end
    end else begin
      waitrequest = 1'b0;
      in_request  = 1'b0;
    end
  end

endmodule

/* test/mips_cpu_bus_tb.sv */
module mips_cpu_bus_tb
  import mips_isa_pkg::*;
();

  localparam word_t DATA_BASE = 32'h0000_1000;
  localparam word_t LOAD_WORD = 32'h1357_9bdf;
  localparam imm_t  K_A = 16'h7ff3;
  localparam imm_t  K_B = 16'h8421;
  localparam imm_t  K_C = 16'h9abc;
  localparam imm_t  K_V = 16'h02f5;
  localparam int    TIMEOUT = 4000;

  localparam reg_idx_t ZERO = 5'd0;
  localparam reg_idx_t T0 = 5'd8;
  localparam reg_idx_t T1 = 5'd9;
  localparam reg_idx_t T2 = 5'd10;
  localparam reg_idx_t T3 = 5'd11;
  localparam reg_idx_t T4 = 5'd12;
  localparam reg_idx_t T5 = 5'd13;
  localparam reg_idx_t T6 = 5'd14;
  localparam reg_idx_t T7 = 5'd15;
  localparam reg_idx_t S0 = 5'd16;
  localparam reg_idx_t S1 = 5'd17;
  localparam reg_idx_t S2 = 5'd18;
  localparam reg_idx_t T8 = 5'd24;
  localparam reg_idx_t T9 = 5'd25;

  logic       clk;
  logic       reset;
  logic       active;
  word_t      register_v0;
  word_t      mem_address;
  logic       memwrite;
  logic       memread;
  logic       waitrequest;
  word_t      memwritedata;
  logic [3:0] byteenable;
  word_t      memreaddata;

  word_t exp_addr[$];
  word_t exp_data[$];
  string exp_name[$];
  int    store_idx;
  int    prog_len;
  logic  first_seen;
  logic  prev_wait;
  word_t prev_addr;
  logic  prev_read;
  logic  prev_write;
  word_t prev_wdata;

  mips_cpu_bus #(
    .RESET_PC (RESET_VECTOR)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .active       (active),
    .register_v0  (register_v0),
    .mem_address  (mem_address),
    .memwrite     (memwrite),
    .memread      (memread),
    .waitrequest  (waitrequest),
    .memwritedata (memwritedata),
    .byteenable   (byteenable),
    .memreaddata  (memreaddata)
  );

  avalon_ram_model #(
    .PROG_BASE (RESET_VECTOR),
    .DATA_BASE (DATA_BASE),
    .SEED      (32'd89)
  ) ram_i (
    .clk         (clk),
    .memread     (memread),
    .memwrite    (memwrite),
    .address     (mem_address),
    .writedata   (memwritedata),
    .waitrequest (waitrequest),
    .readdata    (memreaddata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (expected === actual) else begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                  logic [4:0] sh, funct_t fn);
    return {OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(opcode_t op, word_t target);
    return {op, target[27:2]};
  endfunction

  function automatic word_t instr_addr(input int idx);
    return RESET_VECTOR + 4 * idx;
  endfunction

  task automatic emit(input word_t instr);
    ram_i.load_word(instr_addr(prog_len), instr);
    prog_len++;
  endtask

  task automatic expect_store(input string name, input word_t offset, input word_t value);
    exp_name.push_back(name);
    exp_addr.push_back(DATA_BASE + offset);
    exp_data.push_back(value);
  endtask

  task automatic build_program();
    word_t a;
    word_t b;
    word_t c;
    a = {{16{K_A[15]}}, K_A};
    b = a | {16'h0000, K_B};
    c = {K_C, 16'h0000};
    ram_i.clear_all();
    ram_i.load_word(DATA_BASE + 64, LOAD_WORD);
    prog_len = 0;
    // alu chain with each result stored
    emit(enc_i(OP_ADDIU, ZERO, S0, DATA_BASE[15:0]));
    emit(enc_i(OP_ADDIU, ZERO, T0, K_A));
    emit(enc_i(OP_SW, S0, T0, 16'd0));
    emit(enc_i(OP_ORI, T0, T1, K_B));
    emit(enc_i(OP_SW, S0, T1, 16'd4));
    emit(enc_i(OP_LUI, ZERO, T2, K_C));
    emit(enc_i(OP_SW, S0, T2, 16'd8));
    emit(enc_r(T0, T2, T3, 5'd0, FN_SUBU));
    emit(enc_i(OP_SW, S0, T3, 16'd12));
    emit(enc_r(T1, T2, T4, 5'd0, FN_XOR));
    emit(enc_i(OP_SW, S0, T4, 16'd16));
    emit(enc_r(T2, T0, T5, 5'd0, FN_SLT));
    emit(enc_i(OP_SW, S0, T5, 16'd20));
    emit(enc_r(T2, T0, T6, 5'd0, FN_SLTU));
    emit(enc_i(OP_SW, S0, T6, 16'd24));
    emit(enc_r(ZERO, T1, T7, 5'd5, FN_SLL));
    emit(enc_i(OP_SW, S0, T7, 16'd28));
    emit(enc_r(ZERO, T2, T8, 5'd7, FN_SRL));
    emit(enc_i(OP_SW, S0, T8, 16'd32));
    // load, add, store
    emit(enc_i(OP_LW, S0, T9, 16'd64));
    emit(enc_r(T9, T0, S1, 5'd0, FN_ADDU));
    emit(enc_i(OP_SW, S0, S1, 16'd36));
    // branches with delay slots
    // index 23 is the taken beq
    emit(enc_i(OP_ADDIU, ZERO, S2, 16'd0));
    emit(enc_i(OP_BEQ, S0, S0, 16'd2));
    emit(enc_i(OP_ADDIU, S2, S2, 16'd1));
    emit(enc_i(OP_ADDIU, S2, S2, 16'h0100));
    emit(enc_i(OP_BNE, S0, S0, 16'd2));
    emit(enc_i(OP_ADDIU, S2, S2, 16'd2));
    emit(enc_i(OP_SW, S0, S2, 16'd40));
    // jal at index 29 to the routine at index 35
    emit(enc_j(OP_JAL, instr_addr(35)));
    emit(enc_i(OP_ADDIU, S2, S2, 16'd4));
    emit(enc_i(OP_SW, S0, S2, 16'd44));
    // jump to 0 halts with v0 set in the delay slot
    emit(enc_r(ZERO, ZERO, ZERO, 5'd0, FN_JR));
    emit(enc_i(OP_ADDIU, ZERO, REG_V0, K_V));
    emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'd1));
    emit(enc_i(OP_SW, S0, REG_RA, 16'd48));
    emit(enc_r(REG_RA, ZERO, ZERO, 5'd0, FN_JR));
    emit(enc_i(OP_ADDIU, S2, S2, 16'd8));
    expect_store("addiu", 0, a);
    expect_store("ori", 4, b);
    expect_store("lui", 8, c);
    expect_store("subu", 12, a - c);
    expect_store("xor", 16, b ^ c);
    expect_store("slt", 20, ($signed(c) < $signed(a)) ? 32'd1 : 32'd0);
    expect_store("sltu", 24, (c < a) ? 32'd1 : 32'd0);
    expect_store("sll", 28, b << 5);
    expect_store("srl", 32, c >> 7);
    expect_store("lw addu", 36, LOAD_WORD + a);
    expect_store("branch counter", 40, 32'd3);
    expect_store("jal link", 48, instr_addr(29) + 8);
    expect_store("return counter", 44, 32'd15);
  endtask

  // bus monitor samples once outputs have settled
  always @(posedge clk) begin
    #10;
    if (reset) begin
      check_value("read in reset", 32'd0, {31'b0, memread});
      check_value("write in reset", 32'd0, {31'b0, memwrite});
    end else begin
      if (memread || memwrite) begin
        check_value("byteenable", 32'hf, {28'b0, byteenable});
      end
      if (memread && !first_seen) begin
        check_value("first fetch", RESET_VECTOR, mem_address);
        first_seen = 1'b1;
      end
      if (prev_wait) begin
        check_value("stall address", prev_addr, mem_address);
        check_value("stall read", {31'b0, prev_read}, {31'b0, memread});
        check_value("stall write", {31'b0, prev_write}, {31'b0, memwrite});
        check_value("stall data", prev_wdata, memwritedata);
      end
      if (!active) begin
        check_value("request after halt", 32'd0, {30'b0, memread, memwrite});
      end
      if (memwrite && !waitrequest) begin
        if (store_idx >= exp_addr.size()) begin
          stop_run("more stores than the program makes");
        end
        check_value({exp_name[store_idx], " address"}, exp_addr[store_idx], mem_address);
        check_value({exp_name[store_idx], " data"}, exp_data[store_idx], memwritedata);
        store_idx++;
      end
    end
    prev_wait  = waitrequest && (memread || memwrite);
    prev_addr  = mem_address;
    prev_read  = memread;
    prev_write = memwrite;
    prev_wdata = memwritedata;
  end

  initial begin
    int cycles;
    reset      = 1'b1;
    store_idx  = 0;
    first_seen = 1'b0;
    prev_wait  = 1'b0;
    build_program();
    repeat (8) @(posedge clk);
    #5;
    reset = 1'b0;
    @(posedge clk);
    #10;
    check_value("active after reset", 32'd1, {31'b0, active});
    cycles = 0;
    while (active === 1'b1 && cycles < TIMEOUT) begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (active !== 1'b0) begin
      stop_run("cpu did not halt before the timeout");
    end
    // watch the bus stay idle for a while
    repeat (10) @(posedge clk);
    #15;
    check_value("register_v0", {{16{K_V[15]}}, K_V}, register_v0);
    check_value("store count", exp_addr.size(), store_idx);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* mips_cpu_bus.f */
logic/mips_isa_pkg.sv
logic/mips_ctrl_pkg.sv
logic/mips_cpu_instruction_reg.sv
logic/mips_cpu_register_file.sv
logic/mips_cpu_alu.sv
logic/mips_cpu_alu_control.sv
logic/mips_cpu_controller.sv
logic/mips_cpu_bus.sv
test/avalon_ram_model.sv
test/mips_cpu_bus_tb.sv
